// ==== src/axi_lite_pkg.sv ====
`default_nettype none

package axi_lite_pkg;

  // response codes carried on R and B
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // everything a master drives toward a slave
  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
  } axi_req_t;

  // everything a slave drives back to its master
  typedef struct packed {
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    axi_resp_e   rresp;
    logic        awready;
    logic        wready;
    logic        bvalid;
    axi_resp_e   bresp;
  } axi_rsp_t;

endpackage

`default_nettype wire

// ==== src/soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

  // where the arbiter sends the current transaction
  typedef enum logic [1:0] {
    TARGET_NONE     = 2'd0,
    TARGET_CLINT    = 2'd1,
    TARGET_EXTERNAL = 2'd2
  } bus_target_e;

  // machine timer words, as byte offsets from the CLINT base
  localparam logic [31:0] MTIME_LO_OFFSET = 32'h0000_0048;
  localparam logic [31:0] MTIME_HI_OFFSET = 32'h0000_004c;

  localparam logic [31:0] CLINT_OFFSET_MASK = 32'h0000_00ff; // the CLINT decodes one 'h100 page

endpackage

`default_nettype wire

// ==== src/clint.sv ====
`timescale 1ns/1ns
`default_nettype none

module clint
  import axi_lite_pkg::*;
  import soc_map_pkg::*;
#(
  parameter logic [31:0] CLINT_BASE = 32'ha000_0000
) (
  input  wire logic     clock,
  input  wire logic     reset,
  input  wire axi_req_t req,
  output axi_rsp_t      rsp
);

  logic [63:0] mtime;
  logic        read_pending;
  logic [31:0] read_data;
  axi_resp_e   read_resp;
  logic [31:0] offset;
  logic        ar_fire;

  assign offset  = (req.araddr - CLINT_BASE) & CLINT_OFFSET_MASK;
  assign ar_fire = req.arvalid & ~read_pending;

  // counts cycles since reset
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      read_pending <= 1'b0;
    end else if (ar_fire) begin
      read_pending <= 1'b1;
    end else if (req.rready) begin
      read_pending <= 1'b0; // R handshake since rvalid follows read_pending
    end
  end

  // the word is taken from the timer at the AR handshake
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      if (offset == MTIME_LO_OFFSET) begin
        read_data <= mtime[31:0];
        read_resp <= OKAY;
      end else if (offset == MTIME_HI_OFFSET) begin
        read_data <= mtime[63:32];
        read_resp <= OKAY;
      end else begin
        read_data <= '0;
        read_resp <= SLVERR;
      end
    end
  end

  always_comb begin
    rsp         = '0;
    rsp.arready = ~read_pending;
    rsp.rvalid  = read_pending;
    rsp.rdata   = read_data;
    rsp.rresp   = read_resp;
    rsp.bresp   = OKAY; // write channel stays idle
  end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter
  import axi_lite_pkg::*;
  import soc_map_pkg::*;
#(
  parameter logic [31:0] CLINT_BASE = 32'ha000_0000
) (
  input  wire logic     clock,
  input  wire logic     reset,

  input  wire axi_req_t m0_req,
  output axi_rsp_t      m0_rsp,

  input  wire axi_req_t m1_req,
  output axi_rsp_t      m1_rsp,

  output axi_req_t      ext_req,
  input  wire axi_rsp_t ext_rsp,

  output axi_req_t      clint_req,
  input  wire axi_rsp_t clint_rsp
);

  typedef enum logic {
    IDLE,
    BUSY
  } arb_state_e;

  arb_state_e  state;
  logic        grant_m1;  // low grants master 0
  bus_target_e target;

  axi_req_t granted_req;
  axi_rsp_t target_rsp;
  logic     done;

  // keeps only the AR and R fields of a request
  function automatic axi_req_t read_channels_req(axi_req_t r);
    axi_req_t o;
    o         = '0;
    o.arvalid = r.arvalid;
    o.araddr  = r.araddr;
    o.rready  = r.rready;
    return o;
  endfunction

  // master 0 never writes, so its write responses stay quiet
  function automatic axi_rsp_t read_channels_rsp(axi_rsp_t r);
    axi_rsp_t o;
    o         = '0;
    o.arready = r.arready;
    o.rvalid  = r.rvalid;
    o.rdata   = r.rdata;
    o.rresp   = r.rresp;
    o.bresp   = OKAY;
    return o;
  endfunction

  function automatic logic is_timer_addr(logic [31:0] addr);
    return (addr == CLINT_BASE + MTIME_LO_OFFSET) || (addr == CLINT_BASE + MTIME_HI_OFFSET);
  endfunction

  assign granted_req = grant_m1 ? m1_req : read_channels_req(m0_req);

  // request toward the chosen target, response back from it
  always_comb begin
    ext_req    = '0;
    clint_req  = '0;
    target_rsp = '0;
    case (target)
      TARGET_CLINT: begin
        clint_req  = read_channels_req(granted_req); // only reads are decoded to the CLINT
        target_rsp = clint_rsp;
      end
      TARGET_EXTERNAL: begin
        ext_req    = granted_req;
        target_rsp = ext_rsp;
      end
      default: begin
        target_rsp = '0;
      end
    endcase
  end

  // the master without the grant sees an idle slave
  always_comb begin
    m0_rsp = '0;
    m1_rsp = '0;
    if (grant_m1) begin
      m1_rsp = target_rsp;
    end else begin
      m0_rsp = read_channels_rsp(target_rsp);
    end
  end

  // the transaction ends on the R handshake of a read or the B handshake of a write
  assign done = (target_rsp.rvalid & granted_req.rready) |
                (target_rsp.bvalid & granted_req.bready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= IDLE;
      grant_m1 <= 1'b0;
      target   <= TARGET_NONE;
    end else begin
      case (state)
        IDLE: begin
          if (m0_req.arvalid) begin
            grant_m1 <= 1'b0;
            target   <= is_timer_addr(m0_req.araddr) ? TARGET_CLINT : TARGET_EXTERNAL;
            state    <= BUSY;
          end else if (m1_req.arvalid || m1_req.awvalid) begin
            grant_m1 <= 1'b1;
            if (m1_req.arvalid && is_timer_addr(m1_req.araddr)) begin
              target <= TARGET_CLINT;
            end else begin
              target <= TARGET_EXTERNAL;
            end
            state <= BUSY;
          end
        end
        BUSY: begin
          if (done) begin
            target <= TARGET_NONE;  // grant_m1 matters only while BUSY
            state  <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/soc_bus_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top
  import axi_lite_pkg::*;
#(
  parameter logic [31:0] CLINT_BASE = 32'ha000_0000
) (
  input  wire logic     clock,
  input  wire logic     reset,

  input  wire axi_req_t m0_req,   // instruction fetch, reads only
  output axi_rsp_t      m0_rsp,

  input  wire axi_req_t m1_req,   // load/store
  output axi_rsp_t      m1_rsp,

  output axi_req_t      ext_req,
  input  wire axi_rsp_t ext_rsp
);

  axi_req_t clint_req;
  axi_rsp_t clint_rsp;

  bus_arbiter #(
    .CLINT_BASE (CLINT_BASE)
  ) arbiter (
    .clock     (clock),
    .reset     (reset),
    .m0_req    (m0_req),
    .m0_rsp    (m0_rsp),
    .m1_req    (m1_req),
    .m1_rsp    (m1_rsp),
    .ext_req   (ext_req),
    .ext_rsp   (ext_rsp),
    .clint_req (clint_req),
    .clint_rsp (clint_rsp)
  );

  clint #(
    .CLINT_BASE (CLINT_BASE)
  ) timer (
    .clock (clock),
    .reset (reset),
    .req   (clint_req),
    .rsp   (clint_rsp)
  );

endmodule

`default_nettype wire

// ==== verification/soc_bus_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_bus_properties
  import axi_lite_pkg::*;
  import soc_map_pkg::*;
(
  input wire logic        clock,
  input wire logic        reset,
  input wire logic        grant_m1,
  input wire bus_target_e target,
  input wire axi_rsp_t    m0_rsp,
  input wire axi_rsp_t    m1_rsp,
  input wire axi_req_t    ext_req,
  input wire axi_req_t    clint_req
);

  logic m0_valid;
  logic m1_valid;
  logic ext_valid;
  logic clint_valid;

  assign m0_valid    = m0_rsp.rvalid | m0_rsp.bvalid;
  assign m1_valid    = m1_rsp.rvalid | m1_rsp.bvalid;
  assign ext_valid   = ext_req.arvalid | ext_req.awvalid | ext_req.wvalid;
  assign clint_valid = clint_req.arvalid | clint_req.awvalid | clint_req.wvalid;

  // a response reaches only the master that holds the grant
  m0_valid_needs_grant: assert property (@(posedge clock) disable iff (reset)
    m0_valid |-> (target != TARGET_NONE && !grant_m1))
    else $error("master 0 sees a response valid without holding the grant");

  m1_valid_needs_grant: assert property (@(posedge clock) disable iff (reset)
    m1_valid |-> (target != TARGET_NONE && grant_m1))
    else $error("master 1 sees a response valid without holding the grant");

  targets_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(ext_valid && clint_valid))
    else $error("external port and CLINT are requested in the same cycle");

  // the cycle after reset the bus is idle everywhere
  quiet_after_reset: assert property (@(posedge clock)
    $past(reset) |-> !(m0_valid || m1_valid || ext_valid || clint_valid))
    else $error("a valid is high right after reset");

endmodule

bind bus_arbiter soc_bus_properties arbiter_checks (
  .clock     (clock),
  .reset     (reset),
  .grant_m1  (grant_m1),
  .target    (target),
  .m0_rsp    (m0_rsp),
  .m1_rsp    (m1_rsp),
  .ext_req   (ext_req),
  .clint_req (clint_req)
);

`default_nettype wire

// ==== verification/soc_bus_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_bus_tb
  import axi_lite_pkg::*;
  import soc_map_pkg::*;
();

  localparam logic [31:0] CLINT_BASE = 32'ha000_0000;
  localparam logic [31:0] READ_XOR = 32'h5a5a_5a5a;
  localparam int SEED = 32'h5c5d;
  localparam int NUM_RANDOM = 8;
  localparam int RESET_CYCLES = 16;
  localparam int HOLD_CYCLES = 5;
  localparam int TXN_COUNT = 3 * NUM_RANDOM + 10;  // random loops plus the directed cases
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 50 * TXN_COUNT;

  logic     clock = 1'b0;
  logic     reset;
  axi_req_t m0_req;
  axi_rsp_t m0_rsp;
  axi_req_t m1_req;
  axi_rsp_t m1_rsp;
  axi_req_t ext_req;
  axi_rsp_t ext_rsp;

  string current_test = "";
  int    error_count = 0;

  // what the external slave last saw
  logic [31:0] last_waddr;
  logic [31:0] last_wdata;
  logic [3:0]  last_wstrb;
  int          ext_ar_count;

  always #4 clock = ~clock;

  soc_bus_top #(
    .CLINT_BASE (CLINT_BASE)
  ) dut (
    .clock   (clock),
    .reset   (reset),
    .m0_req  (m0_req),
    .m0_rsp  (m0_rsp),
    .m1_req  (m1_req),
    .m1_rsp  (m1_rsp),
    .ext_req (ext_req),
    .ext_rsp (ext_rsp)
  );

  function automatic logic in_error_range(logic [31:0] addr);
    return addr[31:16] == 16'hdead;
  endfunction

  function automatic logic [31:0] random_addr();
    return 32'h8000_0000 | ($urandom & 32'h0fff_fffc);
  endfunction

  // external slave model with one response per address handshake
  initial begin
    ext_rsp      <= '0;
    ext_ar_count <= 0;
    last_waddr   <= '0;
    last_wdata   <= '0;
    last_wstrb   <= '0;
    forever begin
      @(posedge clock);
      if (reset) begin
        ext_rsp <= '0;
      end else begin
        ext_rsp.arready <= 1'b1;
        ext_rsp.awready <= 1'b1;
        ext_rsp.wready  <= 1'b1;
        if (ext_req.arvalid && ext_rsp.arready) begin
          ext_rsp.rvalid <= 1'b1;
          ext_rsp.rdata  <= ext_req.araddr ^ READ_XOR;
          ext_rsp.rresp  <= in_error_range(ext_req.araddr) ? SLVERR : OKAY;
          ext_ar_count   <= ext_ar_count + 1;
        end else if (ext_rsp.rvalid && ext_req.rready) begin
          ext_rsp.rvalid <= 1'b0;
        end
        if (ext_req.awvalid && ext_rsp.awready) begin
          ext_rsp.bvalid <= 1'b1;
          ext_rsp.bresp  <= OKAY;
          last_waddr     <= ext_req.awaddr;
        end else if (ext_rsp.bvalid && ext_req.bready) begin
          ext_rsp.bvalid <= 1'b0;
        end
        if (ext_req.wvalid && ext_rsp.wready) begin
          last_wdata <= ext_req.wdata;
          last_wstrb <= ext_req.wstrb;
        end
      end
    end
  end

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("ERROR %s %s: expected %h, actual %h", current_test, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "mismatch in %s", current_test);
    end
  endtask

  task automatic read_m0(input logic [31:0] addr, output logic [31:0] data,
                         output axi_resp_e resp);
    @(posedge clock);
    m0_req.arvalid <= 1'b1;
    m0_req.araddr  <= addr;
    m0_req.rready  <= 1'b1;
    do begin
      @(negedge clock);
    end while (!m0_rsp.arready);
    @(posedge clock);  // AR handshake
    m0_req.arvalid <= 1'b0;
    do begin
      @(negedge clock);
    end while (!m0_rsp.rvalid);
    data = m0_rsp.rdata;
    resp = m0_rsp.rresp;
    @(posedge clock);  // R handshake
    m0_req.rready <= 1'b0;
  endtask

  task automatic read_m1(input logic [31:0] addr, output logic [31:0] data,
                         output axi_resp_e resp);
    @(posedge clock);
    m1_req.arvalid <= 1'b1;
    m1_req.araddr  <= addr;
    m1_req.rready  <= 1'b1;
    do begin
      @(negedge clock);
    end while (!m1_rsp.arready);
    @(posedge clock);
    m1_req.arvalid <= 1'b0;
    do begin
      @(negedge clock);
    end while (!m1_rsp.rvalid);
    data = m1_rsp.rdata;
    resp = m1_rsp.rresp;
    @(posedge clock);
    m1_req.rready <= 1'b0;
  endtask

  task automatic write_m1(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output axi_resp_e resp);
    @(posedge clock);
    m1_req.awvalid <= 1'b1;
    m1_req.awaddr  <= addr;
    m1_req.wvalid  <= 1'b1;
    m1_req.wdata   <= data;
    m1_req.wstrb   <= strb;
    m1_req.bready  <= 1'b1;
    do begin
      @(negedge clock);
    end while (!(m1_rsp.awready && m1_rsp.wready));
    @(posedge clock);  // AW and W accepted together
    m1_req.awvalid <= 1'b0;
    m1_req.wvalid  <= 1'b0;
    do begin
      @(negedge clock);
    end while (!m1_rsp.bvalid);
    resp = m1_rsp.bresp;
    @(posedge clock);
    m1_req.bready <= 1'b0;
  endtask

  task automatic random_reads();
    logic [31:0] addr;
    logic [31:0] data;
    axi_resp_e   resp;
    current_test = "random_reads";
    for (int i = 0; i < NUM_RANDOM; i++) begin
      addr = random_addr();
      read_m0(addr, data, resp);
      check("m0 rdata", addr ^ READ_XOR, data);
      check("m0 rresp", 32'(OKAY), 32'(resp));
      addr = random_addr();
      read_m1(addr, data, resp);
      check("m1 rdata", addr ^ READ_XOR, data);
      check("m1 rresp", 32'(OKAY), 32'(resp));
    end
  endtask

  task automatic random_writes();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    axi_resp_e   resp;
    current_test = "random_writes";
    for (int i = 0; i < NUM_RANDOM; i++) begin
      addr = random_addr();
      data = $urandom;
      strb = 4'($urandom);
      write_m1(addr, data, strb, resp);
      check("awaddr", addr, last_waddr);
      check("wdata", data, last_wdata);
      check("wstrb", {28'd0, strb}, {28'd0, last_wstrb});
      check("bresp", 32'(OKAY), 32'(resp));
    end
  endtask

  // master 0 wins the tie and its R comes before master 1's B
  task automatic concurrent_requests();
    logic [31:0] raddr;
    logic [31:0] rdata;
    logic [31:0] waddr;
    logic [31:0] wdata;
    axi_resp_e   rresp;
    axi_resp_e   bresp;
    time         r_time;
    time         b_time;
    logic        r_done;
    logic        b_done;
    int          stray_rsp;
    current_test = "concurrent_requests";
    raddr = random_addr();
    waddr = random_addr();
    wdata = $urandom;
    r_done = 1'b0;
    b_done = 1'b0;
    stray_rsp = 0;
    fork
      begin
        read_m0(raddr, rdata, rresp);
        r_time = $time;
        r_done = 1'b1;
      end
      begin
        write_m1(waddr, wdata, 4'hf, bresp);
        b_time = $time;
        b_done = 1'b1;
      end
      begin
        while (!b_done) begin
          @(negedge clock);
          if (r_done && (m0_rsp != '0)) begin
            stray_rsp++;
          end
        end
      end
    join
    check("m0 rdata", raddr ^ READ_XOR, rdata);
    check("m0 rresp", 32'(OKAY), 32'(rresp));
    check("awaddr", waddr, last_waddr);
    check("wdata", wdata, last_wdata);
    check("bresp", 32'(OKAY), 32'(bresp));
    check("R before B", 32'd1, {31'd0, r_time < b_time});
    check("m0 response during m1 write", 32'd0, stray_rsp);
  endtask

  task automatic timer_reads();
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] high;
    axi_resp_e   resp;
    int          ar_before;
    current_test = "timer_reads";
    ar_before = ext_ar_count;
    read_m1(CLINT_BASE + MTIME_LO_OFFSET, first, resp);
    check("first rresp", 32'(OKAY), 32'(resp));
    read_m1(CLINT_BASE + MTIME_LO_OFFSET, second, resp);
    check("second rresp", 32'(OKAY), 32'(resp));
    check("timer increases", 32'd1, {31'd0, second > first});
    read_m0(CLINT_BASE + MTIME_HI_OFFSET, high, resp);  // run is far too short to carry
    check("high word", 32'd0, high);
    check("high rresp", 32'(OKAY), 32'(resp));
    check("external AR count", ar_before, ext_ar_count);
  endtask

  task automatic error_response();
    logic [31:0] addr;
    logic [31:0] data;
    axi_resp_e   resp;
    current_test = "error_response";
    addr = 32'hdead_0000 | ($urandom & 32'h0000_fffc);
    read_m1(addr, data, resp);
    check("error rresp", 32'(SLVERR), 32'(resp));
    check("error rdata", addr ^ READ_XOR, data);
    addr = random_addr();
    read_m0(addr, data, resp);
    check("m0 rresp after error", 32'(OKAY), 32'(resp));
    addr = random_addr();
    read_m1(addr, data, resp);
    check("m1 rresp after error", 32'(OKAY), 32'(resp));
  endtask

  task automatic read_backpressure();
    logic [31:0] addr0;
    logic [31:0] addr1;
    logic [31:0] held_data;
    int          m0_wait_cycles;
    current_test = "read_backpressure";
    addr0 = random_addr();
    addr1 = random_addr();
    @(posedge clock);
    m1_req.arvalid <= 1'b1;
    m1_req.araddr  <= addr1;
    m1_req.rready  <= 1'b0;
    do begin
      @(negedge clock);
    end while (!m1_rsp.arready);
    @(posedge clock);
    m1_req.arvalid <= 1'b0;
    do begin
      @(negedge clock);
    end while (!m1_rsp.rvalid);
    held_data = m1_rsp.rdata;
    check("m1 rdata", addr1 ^ READ_XOR, held_data);
    @(posedge clock);
    m0_req.arvalid <= 1'b1;  // master 0 asks while master 1 stalls R
    m0_req.araddr  <= addr0;
    m0_req.rready  <= 1'b1;
    repeat (HOLD_CYCLES) begin
      @(negedge clock);
      check("m1 rvalid held", 32'd1, {31'd0, m1_rsp.rvalid});
      check("m1 rdata held", held_data, m1_rsp.rdata);
      check("m0 arready while stalled", 32'd0, {31'd0, m0_rsp.arready});
    end
    @(posedge clock);
    m1_req.rready <= 1'b1;
    @(negedge clock);
    check("m1 rvalid before release", 32'd1, {31'd0, m1_rsp.rvalid});
    check("m0 arready before release", 32'd0, {31'd0, m0_rsp.arready});
    @(posedge clock);  // R handshake
    m1_req.rready <= 1'b0;
    m0_wait_cycles = 0;
    do begin
      @(negedge clock);
      m0_wait_cycles++;
    end while (!m0_rsp.arready);
    // one idle cycle after the R handshake, then master 0 holds the grant
    check("m0 grant delay after m1 R", 32'd2, m0_wait_cycles);
    @(posedge clock);
    m0_req.arvalid <= 1'b0;
    do begin
      @(negedge clock);
    end while (!m0_rsp.rvalid);
    check("m0 rdata", addr0 ^ READ_XOR, m0_rsp.rdata);
    check("m0 rresp", 32'(OKAY), 32'(m0_rsp.rresp));
    @(posedge clock);
    m0_req.rready <= 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    m0_req <= '0;
    m1_req <= '0;
    reset  <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    random_reads();
    random_writes();
    concurrent_requests();
    timer_reads();
    error_response();
    read_backpressure();
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_bus.f ====
src/axi_lite_pkg.sv
src/soc_map_pkg.sv
src/clint.sv
src/bus_arbiter.sv
src/soc_bus_top.sv
verification/soc_bus_properties.sv
verification/soc_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -j 0 \
  --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/soc_bus_sim > sim.log 2>&1
cat sim.log

grep -qF ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -qF ">>> PASS" sim.log || { echo "simulation stopped without a result"; exit 1; }
echo "simulation passed"
